//--- Makefile
TOP = tb_ads816x_adc_ctrl

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- list.f
rtl/ads816x_pkg.sv
rtl/adc_cmd_pkg.sv
rtl/cmd_sequencer.sv
rtl/spi_word_engine.sv
rtl/sample_packer.sv
rtl/ads816x_adc_ctrl.sv
tb/adc_model.sv
tb/tb_ads816x_adc_ctrl.sv

//--- rtl/adc_cmd_pkg.sv
package adc_cmd_pkg;

  ////////////////////
  // Command word layout

  localparam int CMD_BITS   = 32;
  localparam int DATA_BITS  = 32;
  localparam int OP_HI      = 31;  // Opcode field
  localparam int OP_LO      = 30;
  localparam int TRIG_BIT   = 29;  // Wait on triggers instead of delay
  localparam int CONT_BIT   = 28;  // Another command must follow
  localparam int COUNT_BITS = 26;  // Delay or trigger count in 25:0

  // Channel order for SET_ORD, slot k in bits 3k+2..3k
  localparam int CH_BITS     = 3;
  localparam int N_CHANNELS  = 8;
  localparam int SWEEP_WORDS = N_CHANNELS + 1; // Samples come back one word late

  typedef logic [CMD_BITS-1:0]   cmd_word_t;
  typedef logic [DATA_BITS-1:0]  data_word_t; // Two samples per word
  typedef logic [COUNT_BITS-1:0] count_t;
  typedef logic [CH_BITS-1:0]    channel_t;
  typedef logic [3:0]            word_idx_t;  // Sweep word 0..8

  typedef enum logic [1:0] {
    CMD_NO_OP   = 2'b00,  // Delay or trigger wait
    CMD_ADC_RD  = 2'b01,  // Eight channel sweep
    CMD_SET_ORD = 2'b10,  // Load sample order
    CMD_CANCEL  = 2'b11   // End a pending wait
  } opcode_e;

  ////////////////////
  // Sequencer FSM

  typedef enum logic [2:0] {
    S_IDLE      = 3'd0,
    S_DELAY     = 3'd1,
    S_TRIG_WAIT = 3'd2,
    S_ADC_RD    = 3'd3,
    S_ERROR     = 3'd4   // Parked until reset
  } seq_state_e;

endpackage

//--- rtl/ads816x_adc_ctrl.sv
`timescale 1ns/1ps

module ads816x_adc_ctrl (
  input  logic                    clk,
  input  logic                    resetn,
  // Command buffer
  input  adc_cmd_pkg::cmd_word_t  cmd_word,
  input  logic                    cmd_buf_empty,
  output logic                    cmd_word_rd_en,
  // Data buffer
  output adc_cmd_pkg::data_word_t data_word,
  output logic                    data_word_wr_en,
  input  logic                    data_buf_full,
  // Trigger and status
  input  logic                    trigger,
  output logic                    waiting_for_trig,
  output logic                    cmd_buf_underflow,
  output logic                    data_buf_overflow,
  output logic                    unexp_trig,
  // ADC SPI pins
  output logic                    n_cs,
  output logic                    mosi,
  input  logic                    miso
);

  logic                  word_start;
  adc_cmd_pkg::channel_t word_channel;
  logic                  word_capture;
  logic                  word_done;
  logic                  rx_valid;
  ads816x_pkg::sample_t  rx_sample;
  logic                  overflow_event;  // Packer to sequencer
  logic                  in_error;        // Sequencer parked in error

  ////////////////////
  // Command sequencer

  cmd_sequencer cmd_sequencer_i (
    .clk               (clk),
    .resetn            (resetn),
    .cmd_word          (cmd_word),
    .cmd_buf_empty     (cmd_buf_empty),
    .cmd_word_rd_en    (cmd_word_rd_en),
    .trigger           (trigger),
    .waiting_for_trig  (waiting_for_trig),
    .word_start        (word_start),
    .word_channel      (word_channel),
    .word_capture      (word_capture),
    .word_done         (word_done),
    .overflow_event    (overflow_event),
    .cmd_buf_underflow (cmd_buf_underflow),
    .unexp_trig        (unexp_trig),
    .in_error          (in_error)
  );

  ////////////////////
  // SPI word engine

  spi_word_engine spi_word_engine_i (
    .clk          (clk),
    .resetn       (resetn),
    .word_start   (word_start),
    .word_channel (word_channel),
    .word_capture (word_capture),
    .in_error     (in_error),
    .word_done    (word_done),
    .rx_valid     (rx_valid),
    .rx_sample    (rx_sample),
    .n_cs         (n_cs),
    .mosi         (mosi),
    .miso         (miso)
  );

  // Sample pairing into data words
  sample_packer sample_packer_i (
    .clk               (clk),
    .resetn            (resetn),
    .rx_valid          (rx_valid),
    .rx_sample         (rx_sample),
    .in_error          (in_error),
    .data_word         (data_word),
    .data_word_wr_en   (data_word_wr_en),
    .data_buf_full     (data_buf_full),
    .data_buf_overflow (data_buf_overflow),
    .overflow_event    (overflow_event)
  );

endmodule

//--- rtl/ads816x_pkg.sv
package ads816x_pkg;

  ////////////////////
  // Device selection and clocking

  localparam int ADS_MODEL_ID = 8;           // 8 ADS8168, 7 ADS8167, 6 ADS8166
  localparam int SPI_CLK_HZ   = 20_000_000;  // clk frequency

  // Per-model conversion and cycle times in ns
  localparam int T_CONV_NS =
    (ADS_MODEL_ID == 8) ? 660 :
    (ADS_MODEL_ID == 7) ? 1200 :
    2500;                                    // ADS8166 and anything unknown
  localparam int T_CYCLE_NS =
    (ADS_MODEL_ID == 8) ? 1000 :
    (ADS_MODEL_ID == 7) ? 2000 :
    4000;

  ////////////////////
  // SPI framing

  localparam int SPI_WORD_BITS = 16;         // On-the-fly word length
  localparam int OTF_PAD_BITS  = 11;         // Zero fill after prefix and channel

  localparam logic [1:0] OTF_REQ_PREFIX = 2'b10; // Request next channel

  // Rounded-up clk cycles, done in MHz to stay inside 32 bits
  localparam int CLK_MHZ          = SPI_CLK_HZ / 1_000_000;
  localparam int N_CONV_CYCLES    = (T_CONV_NS * CLK_MHZ + 999) / 1000;
  localparam int N_CYCLE_CYCLES   = (T_CYCLE_NS * CLK_MHZ + 999) / 1000;
  localparam int N_CYCLE_LESS_SPI = N_CYCLE_CYCLES - SPI_WORD_BITS;
  localparam int NCS_MAX_A        =
    (N_CONV_CYCLES > N_CYCLE_LESS_SPI) ? N_CONV_CYCLES : N_CYCLE_LESS_SPI;
  localparam int NCS_HIGH_CYCLES  = (NCS_MAX_A > 3) ? NCS_MAX_A : 3; // 14 for ADS8168

  ////////////////////
  // Data widths

  typedef logic [SPI_WORD_BITS-1:0] sample_t;  // One ADC conversion
  typedef logic [7:0]               ncs_timer_t; // n_cs high time counter
  typedef logic [4:0]               spi_bit_t;   // Bits left in the word

endpackage

//--- rtl/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer (
  input  logic                   clk,
  input  logic                   resetn,
  input  adc_cmd_pkg::cmd_word_t cmd_word,
  input  logic                   cmd_buf_empty,
  output logic                   cmd_word_rd_en,
  input  logic                   trigger,
  output logic                   waiting_for_trig,
  output logic                   word_start,
  output adc_cmd_pkg::channel_t  word_channel,
  output logic                   word_capture,
  input  logic                   word_done,
  input  logic                   overflow_event,
  output logic                   cmd_buf_underflow,
  output logic                   unexp_trig,
  output logic                   in_error
);

  adc_cmd_pkg::seq_state_e state, next_cmd_state;
  adc_cmd_pkg::opcode_e    opcode;
  adc_cmd_pkg::count_t     cmd_count;
  adc_cmd_pkg::count_t     delay_timer;
  adc_cmd_pkg::count_t     trig_cnt;
  adc_cmd_pkg::channel_t   sample_order [adc_cmd_pkg::N_CHANNELS];
  adc_cmd_pkg::word_idx_t  word_idx;

  logic wait_trig;    // Latched trig flag of current command
  logic expect_next;  // Latched continue flag
  logic sweep_done;   // Pulse after last word of a sweep
  logic in_flight;    // SPI word between start and done
  logic is_wait_cmd;
  logic cmd_done, next_cmd, cancel_wait, last_word;
  logic trig_err, underflow_err, err;

  ////////////////////
  // Command decode

  assign opcode      = adc_cmd_pkg::opcode_e'(cmd_word[adc_cmd_pkg::OP_HI:adc_cmd_pkg::OP_LO]);
  assign cmd_count   = cmd_word[adc_cmd_pkg::COUNT_BITS-1:0];
  assign is_wait_cmd = (opcode == adc_cmd_pkg::CMD_NO_OP) || (opcode == adc_cmd_pkg::CMD_ADC_RD);
  assign last_word   = (word_idx == adc_cmd_pkg::word_idx_t'(adc_cmd_pkg::SWEEP_WORDS - 1));

  // CANCEL ends a wait, or the wait that follows a sweep
  assign cancel_wait = !cmd_buf_empty && (opcode == adc_cmd_pkg::CMD_CANCEL)
                       && ((state == adc_cmd_pkg::S_DELAY)
                           || (state == adc_cmd_pkg::S_TRIG_WAIT)
                           || (state == adc_cmd_pkg::S_ADC_RD && sweep_done));

  // Current command has finished
  assign cmd_done = (state == adc_cmd_pkg::S_IDLE && !cmd_buf_empty)
                    || (state == adc_cmd_pkg::S_DELAY && delay_timer == '0)
                    || (state == adc_cmd_pkg::S_TRIG_WAIT && trigger && trig_cnt == '0)
                    || (state == adc_cmd_pkg::S_ADC_RD && sweep_done && !wait_trig
                        && delay_timer == '0);
  assign next_cmd = cmd_done && !cmd_buf_empty;

  always_comb begin
    if (cmd_buf_empty) begin
      next_cmd_state = adc_cmd_pkg::S_IDLE;  // Underflow handled by err
    end else begin
      case (opcode)
        adc_cmd_pkg::CMD_NO_OP:  next_cmd_state = cmd_word[adc_cmd_pkg::TRIG_BIT]
                                                  ? adc_cmd_pkg::S_TRIG_WAIT
                                                  : adc_cmd_pkg::S_DELAY;
        adc_cmd_pkg::CMD_ADC_RD: next_cmd_state = adc_cmd_pkg::S_ADC_RD;
        default:                 next_cmd_state = adc_cmd_pkg::S_IDLE; // SET_ORD, CANCEL
      endcase
    end
  end

  // Pop strobe, FWFT so the word is consumed this cycle
  assign cmd_word_rd_en = (state != adc_cmd_pkg::S_ERROR) && (next_cmd || cancel_wait);

  ////////////////////
  // FSM

  assign trig_err      = trigger && (state != adc_cmd_pkg::S_TRIG_WAIT);
  assign underflow_err = cmd_done && expect_next && cmd_buf_empty;
  assign err           = trig_err || underflow_err || overflow_event;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= adc_cmd_pkg::S_IDLE;
    end else if (err) begin
      state <= adc_cmd_pkg::S_ERROR;
    end else if (cancel_wait) begin
      state <= adc_cmd_pkg::S_IDLE;
    end else if (cmd_done) begin
      state <= next_cmd_state;
    end else if (state == adc_cmd_pkg::S_ADC_RD && sweep_done) begin
      state <= wait_trig ? adc_cmd_pkg::S_TRIG_WAIT : adc_cmd_pkg::S_DELAY; // Post-sweep wait
    end
  end

  assign waiting_for_trig = (state == adc_cmd_pkg::S_TRIG_WAIT);
  assign in_error         = (state == adc_cmd_pkg::S_ERROR);

  // Flags of the command being run
  always_ff @(posedge clk) begin
    if (!resetn || in_error || cancel_wait) begin
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
    end else if (next_cmd) begin
      wait_trig   <= is_wait_cmd && cmd_word[adc_cmd_pkg::TRIG_BIT];
      expect_next <= is_wait_cmd && cmd_word[adc_cmd_pkg::CONT_BIT];
    end
  end

  ////////////////////
  // Delay timer and trigger counter

  always_ff @(posedge clk) begin
    if (!resetn || in_error || cancel_wait) begin
      delay_timer <= '0;
    end else if (next_cmd && is_wait_cmd && !cmd_word[adc_cmd_pkg::TRIG_BIT]) begin
      delay_timer <= cmd_count;  // Runs from pop, also during a sweep
    end else if (delay_timer != '0) begin
      delay_timer <= delay_timer - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || in_error || cancel_wait) begin
      trig_cnt <= '0;
    end else if (next_cmd && is_wait_cmd && cmd_word[adc_cmd_pkg::TRIG_BIT]) begin
      trig_cnt <= cmd_count;
    end else if (trigger && trig_cnt != '0) begin
      trig_cnt <= trig_cnt - 1'b1;  // Count N triggers, the next one ends the wait
    end
  end

  ////////////////////
  // Sample order, identity after reset

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int k = 0; k < adc_cmd_pkg::N_CHANNELS; k++) begin
        sample_order[k] <= adc_cmd_pkg::channel_t'(k);
      end
    end else if (next_cmd && opcode == adc_cmd_pkg::CMD_SET_ORD) begin
      for (int k = 0; k < adc_cmd_pkg::N_CHANNELS; k++) begin
        sample_order[k] <= cmd_word[adc_cmd_pkg::CH_BITS*k +: adc_cmd_pkg::CH_BITS];
      end
    end
  end

  ////////////////////
  // Sweep words

  always_ff @(posedge clk) begin
    if (!resetn || in_error) begin
      word_idx   <= '0;
      sweep_done <= 1'b0;
      word_start <= 1'b0;
    end else begin
      if (next_cmd && opcode == adc_cmd_pkg::CMD_ADC_RD) begin
        word_idx <= '0;
      end else if (state == adc_cmd_pkg::S_ADC_RD && word_done && !last_word) begin
        word_idx <= word_idx + 1'b1;
      end
      sweep_done <= (state == adc_cmd_pkg::S_ADC_RD) && word_done && last_word;
      // Next word goes out the cycle after word_done
      word_start <= (next_cmd && opcode == adc_cmd_pkg::CMD_ADC_RD)
                    || (state == adc_cmd_pkg::S_ADC_RD && word_done && !last_word);
    end
  end

  // Word 8 wraps to slot 0 and only collects the last sample
  assign word_channel = sample_order[word_idx[adc_cmd_pkg::CH_BITS-1:0]];
  assign word_capture = (word_idx != '0);  // Word 0 carries no sample

  always_ff @(posedge clk) begin
    if (!resetn || in_error) begin
      in_flight <= 1'b0;
    end else if (word_start) begin
      in_flight <= 1'b1;
    end else if (word_done) begin
      in_flight <= 1'b0;
    end
  end

  ////////////////////
  // Sticky errors

  always_ff @(posedge clk) begin
    if (!resetn) begin
      unexp_trig        <= 1'b0;
      cmd_buf_underflow <= 1'b0;
    end else begin
      if (trig_err)      unexp_trig        <= 1'b1;
      if (underflow_err) cmd_buf_underflow <= 1'b1;
    end
  end

  // Pop only from a non-empty buffer
  a_pop_not_empty: assert property (@(posedge clk) disable iff (!resetn)
    cmd_word_rd_en |-> !cmd_buf_empty)
    else $error("command popped from empty buffer");

  // One SPI word on the pins at a time
  a_one_word: assert property (@(posedge clk) disable iff (!resetn)
    word_start |-> !in_flight)
    else $error("word_start while a word is in flight");

endmodule

//--- rtl/sample_packer.sv
`timescale 1ns/1ps

module sample_packer (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    rx_valid,
  input  ads816x_pkg::sample_t    rx_sample,
  input  logic                    in_error,
  output adc_cmd_pkg::data_word_t data_word,
  output logic                    data_word_wr_en,
  input  logic                    data_buf_full,
  output logic                    data_buf_overflow,
  output logic                    overflow_event
);

  logic                 have_first;    // First sample of a pair is held
  ads816x_pkg::sample_t first_sample;
  logic                 pair_ready;

  assign pair_ready     = rx_valid && have_first;
  assign overflow_event = pair_ready && data_buf_full;  // Pair dropped

  ////////////////////
  // Pairing

  always_ff @(posedge clk) begin
    if (!resetn || in_error) begin
      have_first <= 1'b0;
    end else if (rx_valid) begin
      have_first <= ~have_first;  // Alternate hold and emit
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && !have_first) begin
      first_sample <= rx_sample;
    end
  end

  ////////////////////
  // Data buffer write

  always_ff @(posedge clk) begin
    if (!resetn) begin
      data_word_wr_en <= 1'b0;
    end else begin
      data_word_wr_en <= pair_ready && !data_buf_full;  // One-cycle write
    end
  end

  // Second sample upper, first lower
  always_ff @(posedge clk) begin
    if (pair_ready && !data_buf_full) begin
      data_word <= {rx_sample, first_sample};
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      data_buf_overflow <= 1'b0;
    end else if (overflow_event) begin
      data_buf_overflow <= 1'b1;  // Sticky until reset
    end
  end

endmodule

//--- rtl/spi_word_engine.sv
`timescale 1ns/1ps

module spi_word_engine (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  word_start,
  input  adc_cmd_pkg::channel_t word_channel,
  input  logic                  word_capture,
  input  logic                  in_error,
  output logic                  word_done,
  output logic                  rx_valid,
  output ads816x_pkg::sample_t  rx_sample,
  output logic                  n_cs,
  output logic                  mosi,
  input  logic                  miso
);

  ads816x_pkg::ncs_timer_t ncs_timer;  // Remaining n_cs high cycles
  ads816x_pkg::spi_bit_t   bit_cnt;    // Nonzero while n_cs is low
  logic                    capture_q;  // This word returns a sample

  logic [ads816x_pkg::SPI_WORD_BITS-1:0] tx_shift;
  logic [ads816x_pkg::SPI_WORD_BITS-2:0] rx_shift;  // Last bit taken straight from miso

  ////////////////////
  // n_cs timing

  // The start cycle counts as the first high cycle
  always_ff @(posedge clk) begin
    if (!resetn || in_error) begin
      ncs_timer <= '0;
      bit_cnt   <= '0;
      n_cs      <= 1'b1;   // Deselected
      capture_q <= 1'b0;
    end else begin
      if (word_start) begin
        ncs_timer <= ads816x_pkg::ncs_timer_t'(ads816x_pkg::NCS_HIGH_CYCLES - 1);
        capture_q <= word_capture;
      end else if (ncs_timer != '0) begin
        ncs_timer <= ncs_timer - 1'b1;
      end

      if (ncs_timer == ads816x_pkg::ncs_timer_t'(1)) begin
        n_cs    <= 1'b0;    // High time met, select ADC
        bit_cnt <= ads816x_pkg::spi_bit_t'(ads816x_pkg::SPI_WORD_BITS);
      end else if (bit_cnt != '0) begin
        bit_cnt <= bit_cnt - 1'b1;
        if (bit_cnt == ads816x_pkg::spi_bit_t'(1)) begin
          n_cs <= 1'b1;     // Word complete
        end
      end
    end
  end

  assign word_done = (bit_cnt == ads816x_pkg::spi_bit_t'(1));  // Last low cycle
  assign rx_valid  = word_done && capture_q;

  ////////////////////
  // Shift registers

  // On-the-fly request, prefix then channel then zeros, MSB first
  always_ff @(posedge clk) begin
    if (word_start) begin
      tx_shift <= {ads816x_pkg::OTF_REQ_PREFIX, word_channel, {ads816x_pkg::OTF_PAD_BITS{1'b0}}};
    end else if (bit_cnt != '0) begin
      tx_shift <= {tx_shift[ads816x_pkg::SPI_WORD_BITS-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (bit_cnt != '0) begin
      rx_shift <= {rx_shift[ads816x_pkg::SPI_WORD_BITS-3:0], miso}; // Sample on rising edge
    end
  end

  assign rx_sample = {rx_shift, miso};  // Final bit joins in the done cycle
  assign mosi      = tx_shift[ads816x_pkg::SPI_WORD_BITS-1] & ~n_cs; // Quiet while deselected

  // n_cs low exactly while bits are being shifted
  a_ncs_low_bits: assert property (@(posedge clk) disable iff (!resetn)
    !n_cs |-> (bit_cnt != '0))
    else $error("n_cs low with bit counter idle");

endmodule

//--- tb/adc_model.sv
`timescale 1ns/1ps

module adc_model (
  input  logic clk,
  input  logic resetn,
  input  logic n_cs,
  input  logic mosi,
  output logic miso,
  output logic bad_request   // Sticky, malformed on-the-fly word seen
);

  logic [15:0] req_shift;     // MOSI bits of the word so far
  logic [15:0] req_word;      // Whole request in the last bit cycle
  logic [15:0] tx_word;       // Sample sent back during the current word
  logic        miso_drv = 1'b0;
  int          bit_idx;       // Bit cycles done in this word

  // Channel c answers 16'hC000 + c * 16'h0101
  function automatic logic [15:0] channel_sample(input logic [2:0] ch);
    return 16'hC000 + {13'd0, ch} * 16'h0101;
  endfunction

  assign req_word = {req_shift[14:0], mosi};
  assign miso     = miso_drv;

  ////////////////////
  // MOSI decode, one bit per rising edge while selected

  always @(posedge clk) begin
    if (!resetn) begin
      bit_idx     <= 0;
      req_shift   <= '0;
      tx_word     <= '0;             // Word 0 returns nothing useful
      bad_request <= 1'b0;
    end else if (!n_cs) begin
      req_shift <= req_word;
      if (bit_idx == 15) begin
        bit_idx <= 0;
        tx_word <= channel_sample(req_word[13:11]);  // Goes out next word
        if (req_word[15:14] != 2'b10 || req_word[10:0] != '0) begin
          bad_request <= 1'b1;
        end
      end else begin
        bit_idx <= bit_idx + 1;
      end
    end
  end

  ////////////////////
  // MISO, MSB first, changed on the falling edge

  always @(negedge clk) begin
    if (!resetn || n_cs) begin
      miso_drv <= 1'b0;
    end else begin
      miso_drv <= tx_word[15 - bit_idx];
    end
  end

endmodule

//--- tb/tb_ads816x_adc_ctrl.sv
`timescale 1ns/1ps

module tb_ads816x_adc_ctrl;

  localparam int WORD_CYCLES   = 30;                  // n_cs high plus 16 bits
  localparam int SWEEP_CYCLES  = 9 * WORD_CYCLES;
  localparam int QUIET_CYCLES  = SWEEP_CYCLES;        // Window that must stay silent
  localparam int SETTLE_CYCLES = 2 * WORD_CYCLES;
  localparam int CANCEL_LIMIT  = 20;                  // Cancel must end the delay by then
  localparam int LONG_DELAY    = 50_000;
  localparam int TEST_CYCLES   = 4 * 8 + 4 * SWEEP_CYCLES + 3 * QUIET_CYCLES
                                 + 4 * SETTLE_CYCLES + 100;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                    clk = 1'b0;
  logic                    resetn;
  adc_cmd_pkg::cmd_word_t  cmd_word;
  logic                    cmd_buf_empty;
  logic                    cmd_word_rd_en;
  adc_cmd_pkg::data_word_t data_word;
  logic                    data_word_wr_en;
  logic                    data_buf_full;
  logic                    trigger;
  logic                    waiting_for_trig;
  logic                    cmd_buf_underflow, data_buf_overflow, unexp_trig;
  logic                    n_cs, mosi, miso;
  logic                    bad_request;

  adc_cmd_pkg::cmd_word_t  cmd_q[$];    // Command buffer, FWFT
  adc_cmd_pkg::data_word_t sink_q[$];   // Data buffer contents
  logic [2:0]              order_exp [8];
  logic                    pop_due = 1'b0;
  logic                    n_cs_q = 1'b1;
  int                      pops_seen, ncs_falls, cycle_cnt, check_cnt, error_cnt;

  always #5 clk = ~clk;

  ads816x_adc_ctrl ads816x_adc_ctrl_i (.*);

  adc_model adc_model_i (
    .clk         (clk),
    .resetn      (resetn),
    .n_cs        (n_cs),
    .mosi        (mosi),
    .miso        (miso),
    .bad_request (bad_request)
  );

  ////////////////////
  // Buffers and monitors

  function automatic void refresh_cmd_inputs();
    cmd_buf_empty = (cmd_q.size() == 0);
    cmd_word      = (cmd_q.size() != 0) ? cmd_q[0] : '0;
  endfunction

  always @(posedge clk) begin
    if (resetn && cmd_word_rd_en) begin
      pop_due = 1'b1;                     // Removed at the falling edge
      pops_seen++;
    end
    if (resetn && n_cs_q && !n_cs) ncs_falls++;
    n_cs_q = n_cs;
    if (data_word_wr_en) sink_q.push_back(data_word);
  end

  always @(negedge clk) begin
    if (pop_due && cmd_q.size() != 0) begin
      void'(cmd_q.pop_front());
      refresh_cmd_inputs();
    end
    pop_due = 1'b0;
  end

  // Hang guard
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the DUT stopped making progress after %0d cycles", cycle_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////
  // Helpers

  function automatic adc_cmd_pkg::cmd_word_t make_cmd(input adc_cmd_pkg::opcode_e op,
                                                      input logic trig, input logic cont,
                                                      input logic [31:0] count);
    adc_cmd_pkg::cmd_word_t w;
    w        = '0;
    w[31:30] = op;
    w[29]    = trig;
    w[28]    = cont;
    w[25:0]  = count[25:0];   // Also holds the SET_ORD slots
    return w;
  endfunction

  function automatic logic [15:0] chan_sample(input logic [2:0] ch);
    return 16'hC000 + {13'd0, ch} * 16'h0101;
  endfunction

  task automatic push_cmd(input adc_cmd_pkg::cmd_word_t w);
    cmd_q.push_back(w);
    refresh_cmd_inputs();
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic pulse_trigger();
    trigger = 1'b1;
    @(negedge clk);
    trigger = 1'b0;
  endtask

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    check_cnt++;
    if (expected !== actual) begin
      error_cnt++;
      $display("Fail %s: expected %0h, got %0h", name, expected, actual);
    end
  endtask

  task automatic note_failure(input string msg);
    error_cnt++;
    $display("Error: %s", msg);
  endtask

  task automatic reset_dut();
    resetn        = 1'b0;
    data_buf_full = 1'b0;
    trigger       = 1'b0;
    cmd_q.delete();
    sink_q.delete();
    refresh_cmd_inputs();
    for (int k = 0; k < 8; k++) order_exp[k] = 3'(k);  // Identity after reset
    wait_cycles(8);
    resetn    = 1'b1;
    pops_seen = 0;
    ncs_falls = 0;
  endtask

  // Four words, second sample upper, first lower
  task automatic check_sweep_words(input string name);
    logic [31:0] expected;
    compare_values({name, " words"}, 4, sink_q.size());
    for (int j = 0; j < 4 && j < sink_q.size(); j++) begin
      expected = {chan_sample(order_exp[2*j+1]), chan_sample(order_exp[2*j])};
      compare_values({name, " data"}, expected, sink_q[j]);
    end
    compare_values({name, " request format"}, 0, bad_request);
  endtask

  // Sequencer must stay parked: no pops, no SPI words
  task automatic verify_parked(input string name);
    int pops_before;
    int falls_before;
    pops_before  = pops_seen;
    falls_before = ncs_falls;
    push_cmd(make_cmd(adc_cmd_pkg::CMD_ADC_RD, 1'b0, 1'b0, 1));
    wait_cycles(QUIET_CYCLES);
    compare_values({name, " pops after error"}, pops_before, pops_seen);
    compare_values({name, " n_cs lows after error"}, falls_before, ncs_falls);
    compare_values({name, " n_cs"}, 1, n_cs);
  endtask

  ////////////////////
  // Directed tests

  task automatic check_reset_state();
    compare_values("reset n_cs", 1, n_cs);
    compare_values("reset cmd_word_rd_en", 0, cmd_word_rd_en);
    compare_values("reset data_word_wr_en", 0, data_word_wr_en);
    compare_values("reset waiting_for_trig", 0, waiting_for_trig);
    compare_values("reset cmd_buf_underflow", 0, cmd_buf_underflow);
    compare_values("reset data_buf_overflow", 0, data_buf_overflow);
    compare_values("reset unexp_trig", 0, unexp_trig);
    wait_cycles(4);
    compare_values("reset idle pops", 0, pops_seen);   // Empty queue, nothing to pop
  endtask

  task automatic default_sweep();
    sink_q.delete();
    ncs_falls = 0;
    push_cmd(make_cmd(adc_cmd_pkg::CMD_ADC_RD, 1'b0, 1'b0, $urandom % 16 + 1));
    while (sink_q.size() < 4) @(negedge clk);
    wait_cycles(SETTLE_CYCLES);                        // No extra words may follow
    check_sweep_words("default_sweep");
    compare_values("default_sweep n_cs lows", 9, ncs_falls);
  endtask

  task automatic ordered_sweep();
    int          perm [8];
    int          j;
    int          tmp;
    logic [31:0] slots;
    for (int k = 0; k < 8; k++) perm[k] = k;
    for (int k = 7; k > 0; k--) begin                  // Fisher-Yates shuffle
      j       = $urandom % (k + 1);
      tmp     = perm[k];
      perm[k] = perm[j];
      perm[j] = tmp;
    end
    slots = '0;
    for (int k = 0; k < 8; k++) begin
      slots[3*k +: 3] = perm[k][2:0];
      order_exp[k]    = perm[k][2:0];
    end
    sink_q.delete();
    ncs_falls = 0;
    push_cmd(make_cmd(adc_cmd_pkg::CMD_SET_ORD, 1'b0, 1'b0, slots));
    push_cmd(make_cmd(adc_cmd_pkg::CMD_ADC_RD, 1'b0, 1'b0, $urandom % 16 + 1));
    while (sink_q.size() < 4) @(negedge clk);
    wait_cycles(SETTLE_CYCLES);
    check_sweep_words("ordered_sweep");
    compare_values("ordered_sweep n_cs lows", 9, ncs_falls);
  endtask

  task automatic trigger_wait();
    int n;
    int base;
    n    = $urandom % 4 + 1;
    base = pops_seen;
    push_cmd(make_cmd(adc_cmd_pkg::CMD_NO_OP, 1'b1, 1'b0, n));
    push_cmd(make_cmd(adc_cmd_pkg::CMD_NO_OP, 1'b0, 1'b0, 4));
    while (!waiting_for_trig) @(negedge clk);
    compare_values("trigger_wait first pop", base + 1, pops_seen);
    for (int t = 0; t < n; t++) begin                  // N triggers keep it waiting
      wait_cycles($urandom % 5 + 1);
      pulse_trigger();
      compare_values("trigger_wait still waiting", 1, waiting_for_trig);
      compare_values("trigger_wait no early pop", base + 1, pops_seen);
    end
    wait_cycles($urandom % 5 + 1);
    pulse_trigger();                                   // The (N+1)-th ends it
    compare_values("trigger_wait released", 0, waiting_for_trig);
    compare_values("trigger_wait next pop", base + 2, pops_seen);
    compare_values("trigger_wait unexp_trig", 0, unexp_trig);
    wait_cycles(8);                                    // Short delay runs out
  endtask

  task automatic cancel_delay();
    int base;
    int waited;
    base   = pops_seen;
    waited = 0;
    push_cmd(make_cmd(adc_cmd_pkg::CMD_NO_OP, 1'b0, 1'b0, LONG_DELAY));
    push_cmd(make_cmd(adc_cmd_pkg::CMD_CANCEL, 1'b0, 1'b0, 0));
    push_cmd(make_cmd(adc_cmd_pkg::CMD_NO_OP, 1'b1, 1'b0, 0));
    while (pops_seen < base + 3 && waited < CANCEL_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (pops_seen != base + 3) begin
      note_failure("cancel_delay: the long delay was not cut short by CANCEL");
    end
    compare_values("cancel_delay next command", 1, waiting_for_trig);
    pulse_trigger();
    compare_values("cancel_delay released", 0, waiting_for_trig);
    compare_values("cancel_delay unexp_trig", 0, unexp_trig);
  endtask

  task automatic idle_trigger_error();
    reset_dut();
    pulse_trigger();                                   // Nobody is waiting
    compare_values("idle_trigger_error unexp_trig", 1, unexp_trig);
    compare_values("idle_trigger_error underflow", 0, cmd_buf_underflow);
    compare_values("idle_trigger_error overflow", 0, data_buf_overflow);
    verify_parked("idle_trigger_error");
  endtask

  task automatic underflow_error();
    reset_dut();
    push_cmd(make_cmd(adc_cmd_pkg::CMD_ADC_RD, 1'b0, 1'b1, 2));
    while (!cmd_buf_underflow) @(negedge clk);
    check_sweep_words("underflow_error");              // Raised only after the sweep
    compare_values("underflow_error n_cs lows", 9, ncs_falls);
    compare_values("underflow_error unexp_trig", 0, unexp_trig);
    compare_values("underflow_error overflow", 0, data_buf_overflow);
    verify_parked("underflow_error");
  endtask

  task automatic overflow_error();
    reset_dut();
    data_buf_full = 1'b1;
    push_cmd(make_cmd(adc_cmd_pkg::CMD_ADC_RD, 1'b0, 1'b0, 2));
    while (!data_buf_overflow) @(negedge clk);
    compare_values("overflow_error writes", 0, sink_q.size());
    compare_values("overflow_error n_cs lows", 3, ncs_falls);  // First pair ends in word 2
    compare_values("overflow_error underflow", 0, cmd_buf_underflow);
    data_buf_full = 1'b0;                              // Room again, still no writes
    verify_parked("overflow_error");
    compare_values("overflow_error late writes", 0, sink_q.size());
  endtask

  ////////////////////
  // Run

  initial begin
    void'($urandom(32'hd27b));
    resetn        = 1'b0;
    cmd_word      = '0;
    cmd_buf_empty = 1'b1;
    data_buf_full = 1'b0;
    trigger       = 1'b0;
    reset_dut();
    check_reset_state();
    default_sweep();
    ordered_sweep();
    trigger_wait();
    cancel_delay();
    idle_trigger_error();
    underflow_error();
    overflow_error();
    $display("Checks run: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
